// File: common/framer_pkg.sv
// shared widths and word types; header data packs two LEN_W fields so DATA_W must equal 2*LEN_W
package framer_pkg;

    // datapath widths
    localparam int unsigned DATA_W           = 16;  // payload and egress word width
    localparam int unsigned LEN_W            = 8;   // length field and sequence number width
    localparam int unsigned MAX_FRAME        = 8;   // longest legal frame in payload words

    // buffer sizing, depths kept at powers of two
    localparam int unsigned PAYLOAD_DEPTH    = 16;
    localparam int unsigned PAYLOAD_ALM_FULL = 14;  // ingress stops acking at this fill level
    localparam int unsigned DESC_DEPTH       = 4;   // complete frames waiting to be sent

    // ingress word, also the payload fifo element
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;  // high on the final word of a frame
    } in_word_t;

    // one entry per complete frame in the descriptor fifo
    typedef struct packed {
        logic [LEN_W-1:0] len;  // payload word count, 1..MAX_FRAME
    } desc_t;

    // tags each egress word with its place in the frame
    typedef enum logic [1:0] {
        KIND_HEADER  = 2'd0,
        KIND_PAYLOAD = 2'd1,
        KIND_TRAILER = 2'd2
    } word_kind_e;

    // egress word as seen on the output port
    typedef struct packed {
        word_kind_e        kind;
        logic [DATA_W-1:0] data;
    } out_word_t;

endpackage

// File: fifo/fifo_buf.sv
// DEPTH must be a power of two and at least 2; no fall-through, head shows combinationally
`timescale 1ns/10ps

module fifo_buf #(
    parameter type         dtype       = logic [7:0],
    parameter int unsigned DEPTH       = 8,          // number of entries
    parameter int unsigned ALM_FULL_TH = DEPTH - 1   // alm_full_o once usage reaches this
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,       // async, active low
    input  logic                       push_i,        // write data_i, dropped when full
    input  dtype                       data_i,
    input  logic                       pop_i,         // drop head, ignored when empty
    output dtype                       data_o,        // current head, valid while !empty_o
    output logic                       full_o,
    output logic                       empty_o,
    output logic                       alm_full_o,
    output logic [$clog2(DEPTH+1)-1:0] usage_o        // number of stored entries
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);  // one extra bit to reach DEPTH

    dtype             mem_q [DEPTH];  // entry storage
    logic [PTR_W-1:0] rd_ptr_q;       // points at the head
    logic [PTR_W-1:0] wr_ptr_q;       // next free slot
    logic [CNT_W-1:0] cnt_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i & ~full_o;   // qualified strobes
    assign do_pop  = pop_i & ~empty_o;

    // status from the fill count
    assign full_o     = (cnt_q == CNT_W'(DEPTH));
    assign empty_o    = (cnt_q == '0);
    assign alm_full_o = (cnt_q >= CNT_W'(ALM_FULL_TH));
    assign usage_o    = cnt_q;
    assign data_o     = mem_q[rd_ptr_q];  // pop takes this in the same cycle

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at DEPTH
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;  // idle or push and pop together
            endcase
        end
    end

    // storage write port
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// File: hdl/req_ack_rx.sv
// sender must hold in_word_i while in_req_i is high and keep frames within MAX_FRAME words
`timescale 1ns/10ps

module req_ack_rx (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 in_req_i,      // four-phase request from the sender
    input  framer_pkg::in_word_t in_word_i,
    output logic                 in_ack_o,
    input  logic                 can_accept_i,  // room in both fifos
    output logic                 push_o,        // payload fifo write strobe
    output framer_pkg::in_word_t push_word_o,
    output logic                 desc_push_o,   // descriptor fifo write strobe
    output framer_pkg::desc_t    desc_o
);

    typedef enum logic {
        RX_IDLE,  // ack low, waiting for req
        RX_ACK    // ack high until req falls
    } rx_state_e;

    rx_state_e                    state_q;
    logic                         push_q;  // high for the cycle in which ack rises
    logic [framer_pkg::LEN_W-1:0] len_q;   // words taken so far in this frame

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RX_IDLE;
            push_q  <= 1'b0;
            len_q   <= '0;
        end else begin
            push_q <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    if (in_req_i && can_accept_i) begin  // no ack without fifo room
                        state_q <= RX_ACK;
                        push_q  <= 1'b1;
                    end
                end
                RX_ACK: begin
                    if (!in_req_i) begin
                        state_q <= RX_IDLE;  // ack drops one cycle after req
                    end
                end
            endcase
            if (push_q) begin
                len_q <= in_word_i.last ? '0 : len_q + 1'b1;  // restart on frame end
            end
        end
    end

    assign in_ack_o    = (state_q == RX_ACK);
    assign push_o      = push_q;
    assign push_word_o = in_word_i;  // still stable, req cannot fall before ack
    assign desc_push_o = push_q & in_word_i.last;
    assign desc_o.len  = len_q + 1'b1;  // count includes the word being pushed

endmodule

// File: hdl/req_ack_tx.sv
// load_i is only taken while idle_o is high; a load at any other time is dropped
`timescale 1ns/10ps

module req_ack_tx (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  load_i,      // one-cycle strobe with word_i
    input  framer_pkg::out_word_t word_i,
    output logic                  idle_o,      // ready for the next load
    output logic                  out_req_o,
    output framer_pkg::out_word_t out_word_o,  // held while out_req_o is high
    input  logic                  out_ack_i
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ,      // req high, waiting for ack
        TX_RELEASE   // req low, waiting for ack to fall
    } tx_state_e;

    tx_state_e             state_q;
    framer_pkg::out_word_t word_q;  // word on the wire

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= TX_IDLE;
        end else begin
            case (state_q)
                TX_IDLE:    if (load_i)     state_q <= TX_REQ;
                TX_REQ:     if (out_ack_i)  state_q <= TX_RELEASE;  // drop req next cycle
                TX_RELEASE: if (!out_ack_i) state_q <= TX_IDLE;     // handshake closed
                default:                    state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i && state_q == TX_IDLE) begin
            word_q <= word_i;
        end
    end

    assign idle_o     = (state_q == TX_IDLE);
    assign out_req_o  = (state_q == TX_REQ);
    assign out_word_o = word_q;

endmodule

// File: hdl/checksum_acc.sv
// sum wraps modulo 2^DATA_W; clear_i wins over add_i in the same cycle
`timescale 1ns/10ps

module checksum_acc (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          add_i,    // accumulate word_i
    input  logic [framer_pkg::DATA_W-1:0] word_i,
    input  logic                          clear_i,  // back to zero
    output logic [framer_pkg::DATA_W-1:0] sum_o
);

    logic [framer_pkg::DATA_W-1:0] sum_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sum_q <= '0;
        end else if (clear_i) begin
            sum_q <= '0;
        end else if (add_i) begin
            sum_q <= sum_q + word_i;  // carry out is dropped
        end
    end

    assign sum_o = sum_q;

endmodule

// File: framer/frame_ctrl.sv
// relies on every descriptor arriving after all its payload words are already buffered
`timescale 1ns/10ps

module frame_ctrl (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          desc_empty_i,
    input  framer_pkg::desc_t             desc_i,       // head of descriptor fifo
    output logic                          desc_pop_o,
    input  framer_pkg::in_word_t          pay_word_i,   // head of payload fifo
    output logic                          pay_pop_o,
    input  logic [framer_pkg::DATA_W-1:0] sum_i,        // running payload sum
    output logic                          sum_add_o,
    output logic                          sum_clear_o,
    input  logic                          tx_idle_i,    // sender can take a word
    output logic                          tx_load_o,
    output framer_pkg::out_word_t         tx_word_o
);

    typedef enum logic [1:0] {
        ST_IDLE,     // waiting for a complete frame
        ST_PAYLOAD,  // moving payload words
        ST_TRAILER   // checksum word next
    } ctrl_state_e;

    ctrl_state_e                  state_q;
    ctrl_state_e                  state_d;
    logic [framer_pkg::LEN_W-1:0] rem_q;   // payload words still to send
    logic [framer_pkg::LEN_W-1:0] rem_d;
    logic [framer_pkg::LEN_W-1:0] seq_q;   // frame sequence number, wraps
    logic [framer_pkg::LEN_W-1:0] seq_d;
    logic                         frame_end;

    // counter and last flag agree on well-formed frames
    assign frame_end = (rem_q == 1) | pay_word_i.last;

    always_comb begin
        state_d     = state_q;
        rem_d       = rem_q;
        seq_d       = seq_q;
        desc_pop_o  = 1'b0;
        pay_pop_o   = 1'b0;
        sum_add_o   = 1'b0;
        sum_clear_o = 1'b0;
        tx_load_o   = 1'b0;
        tx_word_o   = '0;
        case (state_q)
            ST_IDLE: begin
                if (!desc_empty_i && tx_idle_i) begin  // header, consume descriptor
                    desc_pop_o     = 1'b1;
                    tx_load_o      = 1'b1;
                    tx_word_o.kind = framer_pkg::KIND_HEADER;
                    tx_word_o.data = {seq_q, desc_i.len};  // seq high byte, length low
                    rem_d          = desc_i.len;
                    state_d        = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                if (tx_idle_i) begin  // pop, send and sum in one cycle
                    pay_pop_o      = 1'b1;
                    sum_add_o      = 1'b1;
                    tx_load_o      = 1'b1;
                    tx_word_o.kind = framer_pkg::KIND_PAYLOAD;
                    tx_word_o.data = pay_word_i.data;
                    rem_d          = rem_q - 1'b1;
                    if (frame_end) begin
                        state_d = ST_TRAILER;
                    end
                end
            end
            ST_TRAILER: begin
                if (tx_idle_i) begin
                    tx_load_o      = 1'b1;
                    tx_word_o.kind = framer_pkg::KIND_TRAILER;
                    tx_word_o.data = sum_i;        // last add landed cycles ago
                    sum_clear_o    = 1'b1;
                    seq_d          = seq_q + 1'b1;
                    state_d        = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            rem_q   <= '0;
            seq_q   <= '0;
        end else begin
            state_q <= state_d;
            rem_q   <= rem_d;
            seq_q   <= seq_d;
        end
    end

endmodule

// File: framer/frame_top.sv
// frames of 1 to MAX_FRAME words only; an unfinished frame stays buffered until its last word
`timescale 1ns/10ps

module frame_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  in_req_i,    // ingress four-phase port
    input  framer_pkg::in_word_t  in_word_i,
    output logic                  in_ack_o,
    output logic                  out_req_o,   // egress four-phase port
    output framer_pkg::out_word_t out_word_o,
    input  logic                  out_ack_i
);

    logic                          can_accept;
    logic                          push;
    framer_pkg::in_word_t          push_word;
    logic                          desc_push;
    framer_pkg::desc_t             desc_in;
    framer_pkg::in_word_t          pay_word;    // payload fifo head
    logic                          pay_pop;
    logic                          pay_alm_full;
    framer_pkg::desc_t             desc_word;   // descriptor fifo head
    logic                          desc_pop;
    logic                          desc_full;
    logic                          desc_empty;
    logic [framer_pkg::DATA_W-1:0] sum;
    logic                          sum_add;
    logic                          sum_clear;
    logic                          tx_idle;
    logic                          tx_load;
    framer_pkg::out_word_t         tx_word;

    // back-pressure from payload level and descriptor room
    assign can_accept = ~pay_alm_full & ~desc_full;

    req_ack_rx i_rx (
        .clk_i,
        .rst_n_i,
        .in_req_i,
        .in_word_i,
        .in_ack_o,
        .can_accept_i (can_accept),
        .push_o       (push),
        .push_word_o  (push_word),
        .desc_push_o  (desc_push),
        .desc_o       (desc_in)
    );

    fifo_buf #(
        .dtype       (framer_pkg::in_word_t),
        .DEPTH       (framer_pkg::PAYLOAD_DEPTH),
        .ALM_FULL_TH (framer_pkg::PAYLOAD_ALM_FULL)
    ) i_pay_fifo (
        .clk_i,
        .rst_n_i,
        .push_i     (push),
        .data_i     (push_word),
        .pop_i      (pay_pop),
        .data_o     (pay_word),
        .full_o     (),              // alm_full throttles long before this
        .empty_o    (),
        .alm_full_o (pay_alm_full),
        .usage_o    ()
    );

    fifo_buf #(
        .dtype       (framer_pkg::desc_t),
        .DEPTH       (framer_pkg::DESC_DEPTH),
        .ALM_FULL_TH (framer_pkg::DESC_DEPTH)
    ) i_desc_fifo (
        .clk_i,
        .rst_n_i,
        .push_i     (desc_push),
        .data_i     (desc_in),
        .pop_i      (desc_pop),
        .data_o     (desc_word),
        .full_o     (desc_full),
        .empty_o    (desc_empty),
        .alm_full_o (),
        .usage_o    ()
    );

    checksum_acc i_csum (
        .clk_i,
        .rst_n_i,
        .add_i   (sum_add),
        .word_i  (pay_word.data),
        .clear_i (sum_clear),
        .sum_o   (sum)
    );

    frame_ctrl i_ctrl (
        .clk_i,
        .rst_n_i,
        .desc_empty_i (desc_empty),
        .desc_i       (desc_word),
        .desc_pop_o   (desc_pop),
        .pay_word_i   (pay_word),
        .pay_pop_o    (pay_pop),
        .sum_i        (sum),
        .sum_add_o    (sum_add),
        .sum_clear_o  (sum_clear),
        .tx_idle_i    (tx_idle),
        .tx_load_o    (tx_load),
        .tx_word_o    (tx_word)
    );

    req_ack_tx i_tx (
        .clk_i,
        .rst_n_i,
        .load_i     (tx_load),
        .word_i     (tx_word),
        .idle_o     (tx_idle),
        .out_req_o,
        .out_word_o,
        .out_ack_i
    );

endmodule

// File: bench/frame_checker.sv
// bound into frame_top; sampled on the rising clock, handshake rules disabled during reset
`timescale 1ns/10ps

module frame_checker (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  in_req_i,
    input logic                  in_ack_i,    // ingress ack from the receiver
    input logic                  out_req_i,   // egress req from the sender
    input framer_pkg::out_word_t out_word_i,
    input logic                  out_ack_i
);

    int unsigned err_cnt = 0;  // failed assertion count

    // both handshakes idle while reset is held
    reset_idle: assert property (@(posedge clk_i) !rst_n_i |-> (!in_ack_i && !out_req_i))
        else begin
            $error("in_ack_o or out_req_o high during reset");
            err_cnt++;
        end

    // ack is raised in the cycle after req was sampled high
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(in_ack_i) |-> $past(in_req_i))
        else begin
            $error("in_ack_o rose while in_req_i was low");
            err_cnt++;
        end

    // ack falls one cycle after req is seen low
    ack_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (in_ack_i && !in_req_i) |=> !in_ack_i)
        else begin
            $error("in_ack_o stayed high after in_req_i fell");
            err_cnt++;
        end

    word_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_req_i ##1 out_req_i) |-> $stable(out_word_i))
        else begin
            $error("out_word_o changed while out_req_o was high");
            err_cnt++;
        end

    req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(out_req_i) |-> $past(!out_ack_i))  // ack low when the word was loaded
        else begin
            $error("out_req_o rose while out_ack_i was still high");
            err_cnt++;
        end

endmodule

bind frame_top frame_checker i_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_req_i   (in_req_i),
    .in_ack_i   (in_ack_o),
    .out_req_i  (out_req_o),
    .out_word_i (out_word_o),
    .out_ack_i  (out_ack_i)
);

// File: bench/frame_tb.sv
// 20 random frames then a stalled egress phase; frames are pre-generated from seed 91
`timescale 1ns/10ps

module frame_tb;

    localparam int unsigned N_BASE    = 20;   // frames with random ack delay
    localparam int unsigned N_STALL   = 10;   // frames sent into the egress stall
    localparam int unsigned N_FRAMES  = N_BASE + N_STALL;
    localparam int unsigned STALL_CYC = 200;
    localparam int unsigned N_DELAY   = 512;  // ack delay table, reused cyclically
    // about 14 cycles per egress word at worst, header and trailer included
    localparam int unsigned TIMEOUT   =
        N_FRAMES * (framer_pkg::MAX_FRAME + 2) * 14 + STALL_CYC + 100;

    logic                          clk;
    logic                          rst_n;
    logic                          in_req;
    framer_pkg::in_word_t          in_word;
    logic                          in_ack;
    logic                          out_req;
    framer_pkg::out_word_t         out_word;
    logic                          out_ack;

    int                            seed = 91;
    int unsigned                   frame_len [N_FRAMES];
    logic [framer_pkg::DATA_W-1:0] frame_data [N_FRAMES][framer_pkg::MAX_FRAME];
    int unsigned                   ack_delay [N_DELAY];
    framer_pkg::out_word_t         exp_q [$];            // expected egress words in order
    logic [framer_pkg::LEN_W-1:0]  exp_seq = '0;
    int unsigned                   accepted = 0;         // payload words acked at ingress
    int unsigned                   delivered = 0;        // payload words seen at egress
    int unsigned                   max_held = 0;         // peak of accepted minus delivered
    int unsigned                   cycle_cnt = 0;
    logic                          stall_pending = 1'b0; // next egress word waits STALL_CYC

    frame_top dut_i (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .in_req_i   (in_req),
        .in_word_i  (in_word),
        .in_ack_o   (in_ack),
        .out_req_o  (out_req),
        .out_word_o (out_word),
        .out_ack_i  (out_ack)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    task automatic step();
        @(posedge clk);
        #2;  // drive and sample away from the edge
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // queue the frame's expected words, then hand its payload over four-phase
    task automatic send_frame(input int unsigned f);
        logic [framer_pkg::DATA_W-1:0] sum;
        logic [framer_pkg::LEN_W-1:0]  len;
        framer_pkg::out_word_t         w;
        sum = '0;
        len = frame_len[f][framer_pkg::LEN_W-1:0];
        w.kind = framer_pkg::KIND_HEADER;
        w.data = {exp_seq, len};  // seq high byte, length low byte
        exp_q.push_back(w);
        for (int unsigned i = 0; i < frame_len[f]; i++) begin
            w.kind = framer_pkg::KIND_PAYLOAD;
            w.data = frame_data[f][i];
            exp_q.push_back(w);
            sum = sum + frame_data[f][i];  // wraps at 16 bits
        end
        w.kind = framer_pkg::KIND_TRAILER;
        w.data = sum;
        exp_q.push_back(w);
        exp_seq = exp_seq + 1'b1;
        for (int unsigned i = 0; i < frame_len[f]; i++) begin
            in_req       = 1'b1;
            in_word.data = frame_data[f][i];
            in_word.last = (i == frame_len[f] - 1);
            do step(); while (!in_ack);
            in_req = 1'b0;
            accepted++;
            do step(); while (in_ack);  // ack low before the next req
        end
    endtask

    // egress side, compares each word and acks after a delay
    initial begin : egress
        int unsigned           n;
        framer_pkg::out_word_t exp;
        n = 0;
        forever begin
            do step(); while (!out_req);
            assert (exp_q.size() != 0) else abort_run("egress word arrived with no frame pending");
            exp = exp_q.pop_front();
            assert (out_word.kind == exp.kind) else abort_run($sformatf(
                "FAILED out_word_o.kind expected %h got %h", exp.kind, out_word.kind));
            assert (out_word.data == exp.data) else abort_run($sformatf(
                "FAILED out_word_o.data expected %h got %h", exp.data, out_word.data));
            if (exp.kind == framer_pkg::KIND_PAYLOAD) begin
                delivered++;
            end
            if (stall_pending) begin
                repeat (STALL_CYC) step();  // upstream fills meanwhile
                stall_pending = 1'b0;
            end else begin
                repeat (ack_delay[n % N_DELAY]) step();
            end
            n++;
            out_ack = 1'b1;
            do step(); while (out_req);
            out_ack = 1'b0;
        end
    end

    // buffered payload bound, settled values at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (accepted - delivered > max_held) begin
                max_held = accepted - delivered;
            end
            assert (accepted - delivered <= framer_pkg::PAYLOAD_ALM_FULL + 1) else
                abort_run($sformatf("FAILED held payload words expected <= %h got %h",
                    framer_pkg::PAYLOAD_ALM_FULL + 1, accepted - delivered));
        end
        if (dut_i.i_checker.err_cnt != 0) begin
            abort_run("a protocol assertion in the checker failed");
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            abort_run($sformatf("run timed out after %0d cycles", cycle_cnt));
        end
    end

    initial begin : stimulus
        int r;
        rst_n   = 1'b0;
        in_req  = 1'b0;
        in_word = '0;
        out_ack = 1'b0;
        for (int unsigned f = 0; f < N_FRAMES; f++) begin
            if (f < N_BASE) begin
                frame_len[f] = 1 + ($unsigned($random(seed)) % framer_pkg::MAX_FRAME);
            end else begin  // long frames so the payload fifo reaches its threshold
                frame_len[f] = framer_pkg::MAX_FRAME / 2 + 1
                    + ($unsigned($random(seed)) % (framer_pkg::MAX_FRAME / 2));
            end
            for (int unsigned i = 0; i < framer_pkg::MAX_FRAME; i++) begin
                r = $random(seed);
                frame_data[f][i] = r[framer_pkg::DATA_W-1:0];
            end
        end
        for (int unsigned d = 0; d < N_DELAY; d++) begin
            ack_delay[d] = $unsigned($random(seed)) % 7;  // 0 to 6 cycles
        end
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;
        for (int unsigned f = 0; f < N_BASE; f++) begin
            send_frame(f);
        end
        while (exp_q.size() != 0) step();  // drain before the stall phase
        stall_pending = 1'b1;
        for (int unsigned f = N_BASE; f < N_FRAMES; f++) begin
            send_frame(f);
        end
        while (exp_q.size() != 0) step();
        repeat (8) step();
        assert (max_held >= framer_pkg::PAYLOAD_ALM_FULL) else
            abort_run("the stall phase never filled the payload buffer to its threshold");
        if (dut_i.i_checker.err_cnt == 0 && accepted == delivered) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("protocol errors or lost payload words at the end of the run");
        end
    end

endmodule

// File: flist.f
common/framer_pkg.sv
fifo/fifo_buf.sv
hdl/req_ack_rx.sv
hdl/req_ack_tx.sv
hdl/checksum_acc.sv
framer/frame_ctrl.sv
framer/frame_top.sv
bench/frame_checker.sv
bench/frame_tb.sv

// File: Bender.yml
package:
  name: frame_builder

sources:
  - common/framer_pkg.sv
  - fifo/fifo_buf.sv
  - hdl/req_ack_rx.sv
  - hdl/req_ack_tx.sv
  - hdl/checksum_acc.sv
  - framer/frame_ctrl.sv
  - framer/frame_top.sv
  - target: simulation
    files:
      - bench/frame_checker.sv
      - bench/frame_tb.sv
